/* src/serializer_pkg.sv */
package serializer_pkg;

   // ready list geometry
   localparam int LOG_READY_LIST_SIZE = 3;
   localparam int READY_LIST_SIZE = 2 ** LOG_READY_LIST_SIZE;

   // task fields
   localparam int N_TASK_TYPES = 4;
   localparam int TASK_TYPE_WIDTH = 2;
   // a request of this type takes any type up to and including it
   localparam int TASK_TYPE_ALL = 3;
   localparam int LOCALE_WIDTH = 32;
   localparam int RO_BIT = 31;
   localparam int ARGS_WIDTH = 32;
   localparam int LOG_CQ_SLICE_SIZE = 7;

   // occupancy thresholds
   localparam int ALMOST_FULL_THRESHOLD = READY_LIST_SIZE - 4;
   localparam int FULL_THRESHOLD = READY_LIST_SIZE - 1;

   typedef logic [TASK_TYPE_WIDTH-1:0] ttype_t;
   typedef logic [LOCALE_WIDTH-1:0] locale_t;
   typedef logic [ARGS_WIDTH-1:0] args_t;
   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;
   typedef logic [LOG_READY_LIST_SIZE-1:0] slot_idx_t;

   // index of the lowest set bit, zero when nothing is set
   function automatic logic [31:0] lowest_set(input logic [31:0] vec);
      logic [31:0] idx;
      idx = '0;
      for (int i = 31; i >= 0; i--) begin
         if (vec[i]) begin
            idx = 32'(i);
         end
      end
      return idx;
   endfunction

endpackage

/* src/ready_slot.sv */
`timescale 1ns/1ns

module ready_slot import serializer_pkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  logic     shift,
   input  logic     load,
   input  logic     next_valid,
   input  logic     next_conflict,
   input  ttype_t   next_ttype,
   input  locale_t  next_locale,
   input  args_t    next_args,
   input  cq_slot_t next_cq_slot,
   input  logic     new_conflict,
   input  ttype_t   new_ttype,
   input  locale_t  new_locale,
   input  args_t    new_args,
   input  cq_slot_t new_cq_slot,
   input  logic     release_here,
   input  logic     release_next,
   output logic     valid,
   output logic     conflict,
   output ttype_t   ttype,
   output locale_t  locale,
   output args_t    args,
   output cq_slot_t cq_slot
);

   // load only ever targets a slot that is shifting or empty,
   // so it takes priority over the shift path
   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid    <= 1'b0;
         conflict <= 1'b0;
      end else if (load) begin
         valid    <= 1'b1;
         conflict <= new_conflict;
      end else if (shift) begin
         valid    <= next_valid;
         // the upper entry may be released while it moves down
         conflict <= next_conflict & !release_next;
      end else if (release_here) begin
         conflict <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         ttype   <= new_ttype;
         locale  <= new_locale;
         args    <= new_args;
         cq_slot <= new_cq_slot;
      end else if (shift) begin
         ttype   <= next_ttype;
         locale  <= next_locale;
         args    <= next_args;
         cq_slot <= next_cq_slot;
      end
   end

endmodule

/* src/enq_ctrl.sv */
`timescale 1ns/1ns

module enq_ctrl import serializer_pkg::*; #(
   parameter int NUM_CORES = 4
) (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 m_valid,
   input  locale_t                              m_locale,
   input  logic [READY_LIST_SIZE-1:0]           slot_valid,
   input  locale_t [READY_LIST_SIZE-1:0]        slot_locale,
   input  logic [NUM_CORES-1:0]                 running_match,
   input  logic [NUM_CORES-1:0]                 finished_core_hit,
   input  logic                                 grant_valid,
   input  slot_idx_t                            grant_index,
   output logic                                 m_ready,
   output logic [READY_LIST_SIZE-1:0]           load,
   output locale_t                              new_locale,
   output logic                                 new_conflict,
   output logic                                 almost_full
);

   logic [READY_LIST_SIZE-1:0] empty_vec;
   logic [READY_LIST_SIZE-1:0] queued_match;
   slot_idx_t                  ins_loc;
   logic                       shifting;
   logic                       accept;
   logic [LOG_READY_LIST_SIZE:0] occupancy;

   assign empty_vec = ~slot_valid;
   assign ins_loc   = slot_idx_t'(lowest_set(32'(empty_vec)));

   assign m_ready = m_valid & !slot_valid[ins_loc] & (occupancy <= FULL_THRESHOLD);
   assign accept  = m_valid & m_ready;

   // the insert slot moves down when the list shifts beneath it
   assign shifting = grant_valid & (ins_loc > grant_index);

   always_comb begin
      for (int i = 0; i < READY_LIST_SIZE; i++) begin
         load[i] = accept & (shifting ? (int'(ins_loc) == i + 1) : (int'(ins_loc) == i));
      end
   end

   // read-only tasks still serialize against writers on the same locale
   always_comb begin
      new_locale         = m_locale;
      new_locale[RO_BIT] = 1'b0;
   end

   always_comb begin
      for (int i = 0; i < READY_LIST_SIZE; i++) begin
         queued_match[i] = slot_valid[i] & (slot_locale[i] == new_locale);
      end
   end

   // a core finishing this cycle no longer holds its locale
   assign new_conflict = m_valid & ((queued_match != '0) |
                                    ((running_match & ~finished_core_hit) != '0));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else if (accept && !grant_valid) begin
         occupancy <= occupancy + 1'b1;
      end else if (!accept && grant_valid) begin
         occupancy <= occupancy - 1'b1;
      end
   end

   assign almost_full = (occupancy >= ALMOST_FULL_THRESHOLD);

endmodule

/* src/dispatch_arbiter.sv */
`timescale 1ns/1ns

module dispatch_arbiter import serializer_pkg::*; #(
   parameter int NUM_CORES = 4,
   localparam int CORE_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic [NUM_CORES-1:0]          s_arvalid,
   input  ttype_t [NUM_CORES-1:0]        s_araddr,
   input  logic [READY_LIST_SIZE-1:0]    slot_valid,
   input  logic [READY_LIST_SIZE-1:0]    slot_conflict,
   input  ttype_t [READY_LIST_SIZE-1:0]  slot_ttype,
   output logic                          grant_valid,
   output slot_idx_t                     grant_index,
   output logic [CORE_W-1:0]             grant_core,
   output logic [NUM_CORES-1:0]          s_rvalid
);

   logic [N_TASK_TYPES-1:0][READY_LIST_SIZE-1:0] type_ready;
   logic [NUM_CORES-1:0]       can_take;
   logic [CORE_W-1:0]          core_sel;
   logic [READY_LIST_SIZE-1:0] task_vec;
   slot_idx_t                  task_sel;

   // eligible slots per requested type
   // the slot handed out last cycle is still in the list until this edge
   always_comb begin
      for (int t = 0; t < N_TASK_TYPES; t++) begin
         for (int j = 0; j < READY_LIST_SIZE; j++) begin
            type_ready[t][j] = slot_valid[j] & !slot_conflict[j]
               & ((t == TASK_TYPE_ALL) ? (slot_ttype[j] <= TASK_TYPE_ALL)
                                       : (slot_ttype[j] == ttype_t'(t)))
               & !(grant_valid & (int'(grant_index) == j));
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         can_take[i] = s_arvalid[i]
            & (type_ready[s_araddr[i]] != '0)
            & !(grant_valid & (int'(grant_core) == i));
      end
   end

   // lowest core wins, then its earliest slot
   assign core_sel = CORE_W'(lowest_set(32'(can_take)));
   assign task_vec = type_ready[s_araddr[core_sel]];
   assign task_sel = slot_idx_t'(lowest_set(32'(task_vec)));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant_valid <= 1'b0;
         grant_core  <= '0;
         grant_index <= '0;
      end else begin
         grant_valid <= (can_take != '0);
         grant_core  <= core_sel;
         // entries above the outgoing slot move down at this edge
         if (grant_valid && (task_sel > grant_index)) begin
            grant_index <= task_sel - 1'b1;
         end else begin
            grant_index <= task_sel;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         s_rvalid[i] = grant_valid & (int'(grant_core) == i);
      end
   end

endmodule

/* src/running_table.sv */
`timescale 1ns/1ns

module running_table import serializer_pkg::*; #(
   parameter int NUM_CORES = 4,
   localparam int CORE_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   grant_valid,
   input  logic [CORE_W-1:0]      grant_core,
   input  locale_t                grant_locale,
   input  logic                   finished_task_valid,
   input  logic [CORE_W-1:0]      finished_task_core,
   input  locale_t                new_locale,
   output logic [NUM_CORES-1:0]   running_match,
   output logic [NUM_CORES-1:0]   finished_core_hit,
   output locale_t                finished_locale,
   output logic                   any_running
);

   locale_t [NUM_CORES-1:0] run_locale;
   logic [NUM_CORES-1:0]    run_valid;

   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         finished_core_hit[i] = finished_task_valid & (int'(finished_task_core) == i);
         running_match[i]     = run_valid[i] & (run_locale[i] == new_locale);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
      end else begin
         for (int i = 0; i < NUM_CORES; i++) begin
            if (grant_valid && (int'(grant_core) == i)) begin
               run_valid[i] <= 1'b1;
            end else if (finished_core_hit[i]) begin
               run_valid[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (grant_valid) begin
         run_locale[grant_core] <= grant_locale;
      end
   end

   assign finished_locale = run_locale[finished_task_core];
   assign any_running     = (run_valid != '0);

endmodule

/* src/conflict_serializer.sv */
`timescale 1ns/1ns

module conflict_serializer import serializer_pkg::*; #(
   parameter int NUM_CORES = 4,
   localparam int CORE_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   m_valid,
   input  ttype_t                 m_ttype,
   input  locale_t                m_locale,
   input  args_t                  m_args,
   input  cq_slot_t               m_cq_slot,
   output logic                   m_ready,
   input  logic [NUM_CORES-1:0]   s_arvalid,
   input  ttype_t [NUM_CORES-1:0] s_araddr,
   output logic [NUM_CORES-1:0]   s_rvalid,
   output ttype_t                 s_rtype,
   output locale_t                s_rlocale,
   output args_t                  s_rargs,
   output cq_slot_t               s_cq_slot,
   input  logic                   finished_task_valid,
   input  logic [CORE_W-1:0]      finished_task_core,
   output logic                   almost_full,
   output logic                   all_cores_idle
);

   logic [READY_LIST_SIZE-1:0]     slot_valid, slot_conflict, load, shift;
   ttype_t [READY_LIST_SIZE-1:0]   slot_ttype;
   locale_t [READY_LIST_SIZE-1:0]  slot_locale;
   args_t [READY_LIST_SIZE-1:0]    slot_args;
   cq_slot_t [READY_LIST_SIZE-1:0] slot_cq_slot;
   logic [READY_LIST_SIZE-1:0]     nxt_valid, nxt_conflict, rel_vec, rel_next, fin_match;
   ttype_t [READY_LIST_SIZE-1:0]   nxt_ttype;
   locale_t [READY_LIST_SIZE-1:0]  nxt_locale;
   args_t [READY_LIST_SIZE-1:0]    nxt_args;
   cq_slot_t [READY_LIST_SIZE-1:0] nxt_cq_slot;
   logic                           grant_valid, new_conflict, any_running;
   slot_idx_t                      grant_index, rel_idx;
   logic [CORE_W-1:0]              grant_core;
   locale_t                        new_locale, finished_locale;
   logic [NUM_CORES-1:0]           running_match, finished_core_hit;

   enq_ctrl #(.NUM_CORES(NUM_CORES)) enq_ctrl_i (
      .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_locale(m_locale),
      .slot_valid(slot_valid), .slot_locale(slot_locale),
      .running_match(running_match), .finished_core_hit(finished_core_hit),
      .grant_valid(grant_valid), .grant_index(grant_index), .m_ready(m_ready),
      .load(load), .new_locale(new_locale), .new_conflict(new_conflict),
      .almost_full(almost_full)
   );

   // each slot shifts from its upper neighbour, the top one takes an empty entry
   assign nxt_valid    = {1'b0, slot_valid[READY_LIST_SIZE-1:1]};
   assign nxt_conflict = {1'b0, slot_conflict[READY_LIST_SIZE-1:1]};
   assign nxt_ttype    = {ttype_t'(0), slot_ttype[READY_LIST_SIZE-1:1]};
   assign nxt_locale   = {locale_t'(0), slot_locale[READY_LIST_SIZE-1:1]};
   assign nxt_args     = {args_t'(0), slot_args[READY_LIST_SIZE-1:1]};
   assign nxt_cq_slot  = {cq_slot_t'(0), slot_cq_slot[READY_LIST_SIZE-1:1]};
   assign rel_next     = {1'b0, rel_vec[READY_LIST_SIZE-1:1]};

   // a finish releases only the earliest waiting task on that locale
   assign rel_idx = slot_idx_t'(lowest_set(32'(fin_match)));

   for (genvar i = 0; i < READY_LIST_SIZE; i++) begin : g_slot
      assign fin_match[i] = finished_task_valid & slot_valid[i]
                            & (slot_locale[i] == finished_locale);
      assign rel_vec[i]   = (fin_match != '0) & (rel_idx == slot_idx_t'(i));
      assign shift[i]     = grant_valid & (slot_idx_t'(i) >= grant_index);

      ready_slot slot_i (
         .clk(clk), .rstn(rstn), .shift(shift[i]), .load(load[i]),
         .next_valid(nxt_valid[i]), .next_conflict(nxt_conflict[i]),
         .next_ttype(nxt_ttype[i]), .next_locale(nxt_locale[i]),
         .next_args(nxt_args[i]), .next_cq_slot(nxt_cq_slot[i]),
         .new_conflict(new_conflict), .new_ttype(m_ttype), .new_locale(new_locale),
         .new_args(m_args), .new_cq_slot(m_cq_slot),
         .release_here(rel_vec[i]), .release_next(rel_next[i]),
         .valid(slot_valid[i]), .conflict(slot_conflict[i]), .ttype(slot_ttype[i]),
         .locale(slot_locale[i]), .args(slot_args[i]), .cq_slot(slot_cq_slot[i])
      );
   end

   dispatch_arbiter #(.NUM_CORES(NUM_CORES)) arbiter_i (
      .clk(clk), .rstn(rstn), .s_arvalid(s_arvalid), .s_araddr(s_araddr),
      .slot_valid(slot_valid), .slot_conflict(slot_conflict), .slot_ttype(slot_ttype),
      .grant_valid(grant_valid), .grant_index(grant_index), .grant_core(grant_core),
      .s_rvalid(s_rvalid)
   );

   // response comes straight from the granted slot before it shifts out
   assign s_rtype   = slot_ttype[grant_index];
   assign s_rlocale = slot_locale[grant_index];
   assign s_rargs   = slot_args[grant_index];
   assign s_cq_slot = slot_cq_slot[grant_index];

   running_table #(.NUM_CORES(NUM_CORES)) running_i (
      .clk(clk), .rstn(rstn), .grant_valid(grant_valid), .grant_core(grant_core),
      .grant_locale(s_rlocale), .finished_task_valid(finished_task_valid),
      .finished_task_core(finished_task_core), .new_locale(new_locale),
      .running_match(running_match), .finished_core_hit(finished_core_hit),
      .finished_locale(finished_locale), .any_running(any_running)
   );

   assign all_cores_idle = (slot_valid == '0) & !any_running;

endmodule

/* verif/serializer_checker.sv */
`timescale 1ns/1ns

module serializer_checker #(
   parameter int NUM_CORES = 4
) (
   input logic                 clk,
   input logic                 rstn,
   input logic                 m_valid,
   input logic                 m_ready,
   input logic [NUM_CORES-1:0] s_rvalid
);

   // at most one core gets a response per cycle
   resp_onehot: assert property (
      @(posedge clk) disable iff (!rstn)
      $onehot0(s_rvalid)
   ) else $error("s_rvalid has more than one bit set");

   // a core is never served twice in a row
   resp_not_back_to_back: assert property (
      @(posedge clk) disable iff (!rstn)
      (s_rvalid & $past(s_rvalid)) == '0
   ) else $error("same core served on consecutive cycles");

   // ready is only offered to a pending task
   ready_needs_valid: assert property (
      @(posedge clk) disable iff (!rstn)
      m_ready |-> m_valid
   ) else $error("m_ready high without m_valid");

   // nothing comes out right after reset
   quiet_after_reset: assert property (
      @(posedge clk)
      $rose(rstn) |-> (s_rvalid == '0)
   ) else $error("s_rvalid set in the first cycle after reset");

endmodule

/* verif/tb_conflict_serializer.sv */
`timescale 1ns/1ns

module tb_conflict_serializer import serializer_pkg::*; ();

   localparam int NUM_CORES   = 4;
   localparam int CORE_W      = $clog2(NUM_CORES);
   localparam int NUM_TASKS   = 400;
   localparam int CYCLE_LIMIT = NUM_TASKS * 30 + 200;

   logic                   clk;
   logic                   rstn;
   logic                   m_valid;
   ttype_t                 m_ttype;
   locale_t                m_locale;
   args_t                  m_args;
   cq_slot_t               m_cq_slot;
   logic                   m_ready;
   logic [NUM_CORES-1:0]   s_arvalid;
   ttype_t [NUM_CORES-1:0] s_araddr;
   logic [NUM_CORES-1:0]   s_rvalid;
   ttype_t                 s_rtype;
   locale_t                s_rlocale;
   args_t                  s_rargs;
   cq_slot_t               s_cq_slot;
   logic                   finished_task_valid;
   logic [CORE_W-1:0]      finished_task_core;
   logic                   almost_full;
   logic                   all_cores_idle;

   // scoreboard indexed by cq slot
   logic    sb_valid  [128];
   ttype_t  sb_type   [128];
   locale_t sb_locale [128];
   args_t   sb_args   [128];
   cq_slot_t order_q [$];

   // per-core model
   logic [NUM_CORES-1:0] busy;
   logic [NUM_CORES-1:0] req_on;
   ttype_t               req_type [NUM_CORES];
   locale_t              run_loc  [NUM_CORES];
   int                   fin_cnt  [NUM_CORES];

   logic [31:0]          lfsr_state;
   logic [NUM_CORES-1:0] prev_rvalid;
   int occ;
   int issued;
   int accepted_cnt;
   int done_cnt;
   int errors;
   int cycles;
   logic drained;

   conflict_serializer #(.NUM_CORES(NUM_CORES)) dut_i (
      .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_ttype(m_ttype),
      .m_locale(m_locale), .m_args(m_args), .m_cq_slot(m_cq_slot), .m_ready(m_ready),
      .s_arvalid(s_arvalid), .s_araddr(s_araddr), .s_rvalid(s_rvalid),
      .s_rtype(s_rtype), .s_rlocale(s_rlocale), .s_rargs(s_rargs), .s_cq_slot(s_cq_slot),
      .finished_task_valid(finished_task_valid), .finished_task_core(finished_task_core),
      .almost_full(almost_full), .all_cores_idle(all_cores_idle)
   );

   bind conflict_serializer serializer_checker #(.NUM_CORES(NUM_CORES)) checker_i (
      .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_ready(m_ready), .s_rvalid(s_rvalid)
   );

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++) begin
         val = {val[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return val;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin : model
      int       pos;
      int       fin_sel;
      logic     accepted;
      logic     idle_exp;
      cq_slot_t cq;
      locale_t  loc;
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with %0d of %0d tasks done", cycles, done_cnt,
                  NUM_TASKS);
         $display("errors: %0d", errors);
         $display("*** FAILED ***");
         $finish;
      end else if (rstn) begin
         if (!$onehot0(s_rvalid)) begin
            errors++;
            $display("more than one core was served in the same cycle");
         end
         if ((s_rvalid & prev_rvalid) != '0) begin
            errors++;
            $display("a core was served on two consecutive cycles");
         end
         prev_rvalid = s_rvalid;
         if (m_ready && !m_valid) begin
            errors++;
            $display("m_ready was high while m_valid was low");
         end
         if (m_ready && occ > FULL_THRESHOLD) begin
            errors++;
            $display("m_ready was high with the ready list full (occupancy %0d)", occ);
         end
         if (almost_full !== (occ >= ALMOST_FULL_THRESHOLD)) begin
            errors++;
            $display("ERROR almost_full: got %h, expected %h", almost_full,
                     occ >= ALMOST_FULL_THRESHOLD);
         end
         idle_exp = (occ == 0) && (busy == '0);
         if (all_cores_idle !== idle_exp) begin
            errors++;
            $display("ERROR all_cores_idle: got %h, expected %h", all_cores_idle, idle_exp);
         end

         // enqueue side
         accepted = m_valid && m_ready;
         if (accepted) begin
            cq = m_cq_slot;
            if (sb_valid[cq]) begin
               errors++;
               $display("cq slot %0d accepted while its previous task was still pending", cq);
            end
            loc         = m_locale;
            loc[RO_BIT] = 1'b0;
            sb_valid[cq]  = 1'b1;
            sb_type[cq]   = m_ttype;
            sb_locale[cq] = loc;
            sb_args[cq]   = m_args;
            order_q.push_back(cq);
            occ++;
            accepted_cnt++;
         end

         // dispatch side
         for (int i = 0; i < NUM_CORES; i++) begin
            if (s_rvalid[i]) begin
               cq = s_cq_slot;
               if (!s_arvalid[i] || !req_on[i]) begin
                  errors++;
                  $display("core %0d was served without a pending request", i);
               end
               if (busy[i]) begin
                  errors++;
                  $display("core %0d was served before finishing its last task", i);
               end
               if (!sb_valid[cq]) begin
                  errors++;
                  $display("dispatch of cq slot %0d which holds no pending task", cq);
               end else begin
                  if (s_rtype !== sb_type[cq]) begin
                     errors++;
                     $display("ERROR s_rtype: got %h, expected %h", s_rtype, sb_type[cq]);
                  end
                  if (s_rlocale !== sb_locale[cq]) begin
                     errors++;
                     $display("ERROR s_rlocale: got %h, expected %h", s_rlocale,
                              sb_locale[cq]);
                  end
                  if (s_rargs !== sb_args[cq]) begin
                     errors++;
                     $display("ERROR s_rargs: got %h, expected %h", s_rargs, sb_args[cq]);
                  end
                  if (req_type[i] != ttype_t'(TASK_TYPE_ALL) && s_rtype != req_type[i]) begin
                     errors++;
                     $display("ERROR s_rtype: got %h, expected %h", s_rtype, req_type[i]);
                  end
                  for (int j = 0; j < NUM_CORES; j++) begin
                     if (j != i && busy[j] && run_loc[j] == sb_locale[cq]) begin
                        errors++;
                        $display("cores %0d and %0d both run locale %h", i, j, sb_locale[cq]);
                     end
                  end
               end
               pos = -1;
               for (int k = 0; k < order_q.size(); k++) begin
                  if (pos < 0 && order_q[k] == cq) begin
                     pos = k;
                  end
               end
               if (pos >= 0) begin
                  for (int k = 0; k < pos; k++) begin
                     if (sb_locale[order_q[k]] == sb_locale[cq]) begin
                        errors++;
                        $display("task in cq slot %0d overtook an earlier task on locale %h",
                                 cq, sb_locale[cq]);
                     end
                  end
                  order_q.delete(pos);
               end
               sb_valid[cq] = 1'b0;
               busy[i]      = 1'b1;
               run_loc[i]   = sb_locale[cq];
               fin_cnt[i]   = int'(rand_bits(4)) + 1;
               req_on[i]    = 1'b0;
               occ--;
               done_cnt++;
            end
         end

         // at most one finish strobe per cycle
         if (finished_task_valid) begin
            busy[finished_task_core] = 1'b0;
         end
         fin_sel = -1;
         for (int i = 0; i < NUM_CORES; i++) begin
            if (busy[i]) begin
               if (fin_cnt[i] > 0) begin
                  fin_cnt[i]--;
               end else if (fin_sel < 0) begin
                  fin_sel = i;
               end
            end
         end
         if (fin_sel >= 0) begin
            finished_task_valid <= 1'b1;
            finished_task_core  <= CORE_W'(fin_sel);
         end else begin
            finished_task_valid <= 1'b0;
         end

         // idle cores raise new requests and the last core takes any type
         for (int i = 0; i < NUM_CORES; i++) begin
            if (!req_on[i] && !busy[i] && rand_bits(1) != 0) begin
               req_on[i] = 1'b1;
               if (i == NUM_CORES - 1) begin
                  req_type[i] = ttype_t'(TASK_TYPE_ALL);
               end else begin
                  req_type[i] = ttype_t'(rand_bits(2));
               end
            end
         end
         for (int i = 0; i < NUM_CORES; i++) begin
            s_arvalid[i] <= req_on[i];
            s_araddr[i]  <= req_type[i];
         end

         // source holds its task under back-pressure
         if (!m_valid || accepted) begin
            if (issued < NUM_TASKS && rand_bits(1) != 0) begin
               loc         = locale_t'(rand_bits(3));
               loc[RO_BIT] = rand_bits(1) != 0;
               m_valid   <= 1'b1;
               m_ttype   <= ttype_t'(rand_bits(2));
               m_locale  <= loc;
               m_args    <= rand_bits(32);
               m_cq_slot <= cq_slot_t'(issued);
               issued++;
            end else begin
               m_valid <= 1'b0;
            end
         end

         if (accepted_cnt == NUM_TASKS && done_cnt == NUM_TASKS && busy == '0
             && !finished_task_valid) begin
            drained = 1'b1;
         end
      end
   end

   initial begin
      lfsr_state = 32'hb8c0121f;
      rstn = 1'b0;
      m_valid = 1'b0;
      m_ttype = '0;
      m_locale = '0;
      m_args = '0;
      m_cq_slot = '0;
      s_arvalid = '0;
      s_araddr = '0;
      finished_task_valid = 1'b0;
      finished_task_core = '0;
      busy = '0;
      req_on = '0;
      prev_rvalid = '0;
      drained = 1'b0;
      for (int i = 0; i < 128; i++) begin
         sb_valid[i] = 1'b0;
      end
      for (int i = 0; i < NUM_CORES; i++) begin
         req_type[i] = '0;
         fin_cnt[i] = 0;
      end
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      wait (drained);
      // end between edges so the last checks of the model are counted
      repeat (4) @(negedge clk);
      if (order_q.size() != 0) begin
         errors++;
         $display("%0d tasks were never dispatched", order_q.size());
      end
      $display("errors: %0d, tasks accepted %0d, dispatched %0d", errors, accepted_cnt,
               done_cnt);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* tb.f */
src/serializer_pkg.sv
src/ready_slot.sv
src/enq_ctrl.sv
src/dispatch_arbiter.sv
src/running_table.sv
src/conflict_serializer.sv
verif/serializer_checker.sv
verif/tb_conflict_serializer.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the serializer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module tb_conflict_serializer -f tb.f

./obj_dir/Vtb_conflict_serializer +verilator+error+limit+100 | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
